/* build.f */
source/lc4_pkg.sv
source/lc4_pipe_if.sv
source/lc4_fetch.sv
source/lc4_regfile.sv
source/lc4_decode.sv
source/lc4_execute.sv
source/lc4_core.sv
tests/tb_clock.sv
tests/tb_lc4_core.sv

/* source/lc4_core.sv */
`timescale 1ns/1ns
`default_nettype none

module lc4_core (
    input  wire                    gwe,
    input  wire                    i_rst_n,
    input  wire  lc4_pkg::word_t   i_cur_insn,
    input  wire  lc4_pkg::word_t   i_cur_dmem_data,
    output lc4_pkg::word_t         o_cur_pc,
    output lc4_pkg::word_t         o_dmem_addr,
    output logic                   o_dmem_we,
    output lc4_pkg::word_t         o_dmem_towrite,
    output lc4_pkg::word_t         o_wb_pc,
    output lc4_pkg::word_t         o_wb_insn,
    output lc4_pkg::stall_t        o_wb_stall,
    output logic                   o_regfile_we,
    output lc4_pkg::reg_sel_t      o_regfile_wsel,
    output lc4_pkg::word_t         o_regfile_data,
    output logic                   o_nzp_we,
    output lc4_pkg::nzp_t          o_nzp_new
);
    import lc4_pkg::*;

    logic  br_taken;
    word_t br_target;

    fetch_if u_fetch_if ();
    exec_if  u_exec_if ();

    lc4_fetch u_fetch (
        .gwe         (gwe),
        .i_rst_n     (i_rst_n),
        .i_cur_insn  (i_cur_insn),
        .i_br_taken  (br_taken),
        .i_br_target (br_target),
        .o_cur_pc    (o_cur_pc),
        .f           (u_fetch_if.producer)
    );

    lc4_decode u_decode (
        .gwe        (gwe),
        .i_rst_n    (i_rst_n),
        .i_br_taken (br_taken),
        .f          (u_fetch_if.consumer),
        .ex         (u_exec_if.producer)
    );

    lc4_execute u_execute (
        .gwe             (gwe),
        .i_rst_n         (i_rst_n),
        .i_cur_dmem_data (i_cur_dmem_data),
        .ex              (u_exec_if.consumer),
        .o_br_taken      (br_taken),
        .o_br_target     (br_target),
        .o_dmem_addr     (o_dmem_addr),
        .o_dmem_we       (o_dmem_we),
        .o_dmem_towrite  (o_dmem_towrite),
        .o_wb_pc         (o_wb_pc),
        .o_wb_insn       (o_wb_insn),
        .o_wb_stall      (o_wb_stall),
        .o_regfile_we    (o_regfile_we),
        .o_regfile_wsel  (o_regfile_wsel),
        .o_regfile_data  (o_regfile_data),
        .o_nzp_we        (o_nzp_we),
        .o_nzp_new       (o_nzp_new)
    );

endmodule

`default_nettype wire

/* source/lc4_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module lc4_decode (
    input  wire       gwe,
    input  wire       i_rst_n,
    input  wire       i_br_taken,
    fetch_if.consumer f,
    exec_if.producer  ex
);
    import lc4_pkg::*;

    dec_ctl_t dec_ctl;
    word_t    rs_data;
    word_t    rt_data;
    logic     hold;

    always_comb begin
        dec_ctl    = '0;
        dec_ctl.rs = f.insn[8:6];
        dec_ctl.rt = f.insn[2:0];
        dec_ctl.rd = f.insn[11:9];
        case (f.insn[15:12])
            OP_ADD, OP_AND: begin
                // immediate form, or register form with subop 000
                if (f.insn[5] || (f.insn[5:3] == 3'b000)) begin
                    dec_ctl.rs_re  = 1'b1;
                    dec_ctl.rt_re  = ~f.insn[5];
                    dec_ctl.reg_we = 1'b1;
                    dec_ctl.nzp_we = 1'b1;
                end
            end
            OP_CONST: begin
                dec_ctl.reg_we = 1'b1;
                dec_ctl.nzp_we = 1'b1;
            end
            OP_LDR: begin
                dec_ctl.rs_re   = 1'b1;
                dec_ctl.reg_we  = 1'b1;
                dec_ctl.nzp_we  = 1'b1;
                dec_ctl.is_load = 1'b1;
            end
            OP_STR: begin
                // store data comes from the rd field
                dec_ctl.rt       = f.insn[11:9];
                dec_ctl.rs_re    = 1'b1;
                dec_ctl.rt_re    = 1'b1;
                dec_ctl.is_store = 1'b1;
            end
            OP_BR: begin
                // BR with no condition bits is the nop
                dec_ctl.is_branch = |f.insn[11:9];
            end
            default: ;
        endcase
        if (f.stall != STALL_NONE) begin
            dec_ctl = '0;
        end
    end

    lc4_regfile u_regfile (
        .gwe       (gwe),
        .i_rst_n   (i_rst_n),
        .i_rs      (dec_ctl.rs),
        .i_rt      (dec_ctl.rt),
        .i_we      (ex.wb_we),
        .i_wsel    (ex.wb_sel),
        .i_wdata   (ex.wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // load in execute feeding this instruction; store data is left to WM bypass
    assign hold = ex.ctl.is_load &&
                  ((dec_ctl.rs_re && (dec_ctl.rs == ex.ctl.rd)) ||
                   (dec_ctl.rt_re && !dec_ctl.is_store && (dec_ctl.rt == ex.ctl.rd)) ||
                   dec_ctl.is_branch);
    assign f.hold = hold;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            ex.ctl   <= '0;
            ex.stall <= STALL_FLUSH;
        end else if (i_br_taken) begin
            ex.ctl   <= '0;
            ex.stall <= STALL_FLUSH;
        end else if (hold) begin
            ex.ctl   <= '0;
            ex.stall <= STALL_LOAD;
        end else begin
            ex.ctl   <= dec_ctl;
            ex.stall <= f.stall;
        end
    end

    always_ff @(posedge gwe) begin
        ex.pc      <= f.pc;
        ex.insn    <= f.insn;
        ex.rs_data <= rs_data;
        ex.rt_data <= rt_data;
    end

    // the bubble behind a hold carries no load, so holds never chain
    a_hold_single : assert property (@(posedge gwe) disable iff (!i_rst_n)
        hold |=> !hold);

endmodule

`default_nettype wire

/* source/lc4_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module lc4_execute (
    input  wire                    gwe,
    input  wire                    i_rst_n,
    input  wire  lc4_pkg::word_t   i_cur_dmem_data,
    exec_if.consumer               ex,
    output logic                   o_br_taken,
    output lc4_pkg::word_t         o_br_target,
    output lc4_pkg::word_t         o_dmem_addr,
    output logic                   o_dmem_we,
    output lc4_pkg::word_t         o_dmem_towrite,
    output lc4_pkg::word_t         o_wb_pc,
    output lc4_pkg::word_t         o_wb_insn,
    output lc4_pkg::stall_t        o_wb_stall,
    output logic                   o_regfile_we,
    output lc4_pkg::reg_sel_t      o_regfile_wsel,
    output lc4_pkg::word_t         o_regfile_data,
    output logic                   o_nzp_we,
    output lc4_pkg::nzp_t          o_nzp_new
);
    import lc4_pkg::*;

    function automatic nzp_t nzp_of(input word_t v);
        if (v == '0) begin
            return 3'b010;
        end
        return v[WORD_W-1] ? 3'b100 : 3'b001;
    endfunction

    word_t    rs_val;
    word_t    rt_val;
    word_t    opnd_b;
    word_t    alu_result;
    nzp_t     nzp_q;
    dec_ctl_t m_ctl;
    stall_t   m_stall;
    word_t    m_pc;
    word_t    m_insn;
    word_t    m_result;
    word_t    m_rt;
    word_t    store_data;
    dec_ctl_t w_ctl;
    stall_t   w_stall;
    word_t    w_pc;
    word_t    w_insn;
    word_t    w_result;
    word_t    w_load;
    word_t    wb_data;

    assign wb_data = w_ctl.is_load ? w_load : w_result;

    // MX before WX before register file
    always_comb begin
        if (m_ctl.reg_we && (m_ctl.rd == ex.ctl.rs)) begin
            rs_val = m_result;
        end else if (w_ctl.reg_we && (w_ctl.rd == ex.ctl.rs)) begin
            rs_val = wb_data;
        end else begin
            rs_val = ex.rs_data;
        end
        if (m_ctl.reg_we && (m_ctl.rd == ex.ctl.rt)) begin
            rt_val = m_result;
        end else if (w_ctl.reg_we && (w_ctl.rd == ex.ctl.rt)) begin
            rt_val = wb_data;
        end else begin
            rt_val = ex.rt_data;
        end
    end

    assign opnd_b = ex.insn[5] ? {{11{ex.insn[4]}}, ex.insn[4:0]} : rt_val;

    always_comb begin
        case (ex.insn[15:12])
            OP_ADD:         alu_result = rs_val + opnd_b;
            OP_AND:         alu_result = rs_val & opnd_b;
            OP_CONST:       alu_result = {{7{ex.insn[8]}}, ex.insn[8:0]};
            OP_LDR, OP_STR: alu_result = rs_val + {{10{ex.insn[5]}}, ex.insn[5:0]};
            OP_BR:          alu_result = ex.pc + 16'd1 + {{7{ex.insn[8]}}, ex.insn[8:0]};
            default:        alu_result = '0;
        endcase
    end

    // younger ALU result wins over an older load finishing memory
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            nzp_q <= '0;
        end else if (ex.ctl.nzp_we && !ex.ctl.is_load) begin
            nzp_q <= nzp_of(alu_result);
        end else if (m_ctl.is_load) begin
            nzp_q <= nzp_of(i_cur_dmem_data);
        end
    end

    assign o_br_taken  = ex.ctl.is_branch && |(nzp_q & ex.insn[11:9]);
    assign o_br_target = alu_result;

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            m_ctl   <= '0;
            m_stall <= STALL_FLUSH;
            w_ctl   <= '0;
            w_stall <= STALL_FLUSH;
        end else begin
            m_ctl   <= ex.ctl;
            m_stall <= ex.stall;
            w_ctl   <= m_ctl;
            w_stall <= m_stall;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc     <= ex.pc;
        m_insn   <= ex.insn;
        m_result <= alu_result;
        m_rt     <= rt_val;
        w_pc     <= m_pc;
        w_insn   <= m_insn;
        w_result <= m_result;
        w_load   <= i_cur_dmem_data;
    end

    // WM bypass of store data
    assign store_data = (w_ctl.reg_we && (w_ctl.rd == m_ctl.rt)) ? wb_data : m_rt;

    assign o_dmem_addr    = (m_ctl.is_load || m_ctl.is_store) ? m_result : '0;
    assign o_dmem_we      = m_ctl.is_store;
    assign o_dmem_towrite = m_ctl.is_store ? store_data : '0;

    assign ex.wb_we   = w_ctl.reg_we;
    assign ex.wb_sel  = w_ctl.rd;
    assign ex.wb_data = wb_data;

    assign o_wb_pc        = w_pc;
    assign o_wb_insn      = w_insn;
    assign o_wb_stall     = w_stall;
    assign o_regfile_we   = w_ctl.reg_we;
    assign o_regfile_wsel = w_ctl.rd;
    assign o_regfile_data = wb_data;
    assign o_nzp_we       = w_ctl.nzp_we;
    assign o_nzp_new      = nzp_of(wb_data);

    a_store_only : assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_dmem_we |-> ((m_insn[15:12] == OP_STR) && (m_stall == STALL_NONE)));

    a_no_bubble_branch : assert property (@(posedge gwe) disable iff (!i_rst_n)
        o_br_taken |-> (ex.stall == STALL_NONE));

endmodule

`default_nettype wire

/* source/lc4_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module lc4_fetch (
    input  wire                   gwe,
    input  wire                   i_rst_n,
    input  wire  lc4_pkg::word_t  i_cur_insn,
    input  wire                   i_br_taken,
    input  wire  lc4_pkg::word_t  i_br_target,
    output lc4_pkg::word_t        o_cur_pc,
    fetch_if.producer             f
);
    import lc4_pkg::*;

    word_t pc_q;
    word_t pc_next;

    assign o_cur_pc = pc_q;

    // a taken branch wins over a load stall
    always_comb begin
        if (i_br_taken) begin
            pc_next = i_br_target;
        end else if (f.hold) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + word_t'(1);
        end
    end

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    // stall code of the instruction entering decode
    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            f.stall <= STALL_FLUSH;
        end else if (i_br_taken) begin
            f.stall <= STALL_FLUSH;
        end else if (!f.hold) begin
            f.stall <= STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!f.hold) begin
            f.pc   <= pc_q;
            f.insn <= i_cur_insn;
        end
    end

    // decode holds only for a load in execute, never alongside a redirect
    a_pc_held : assert property (@(posedge gwe) disable iff (!i_rst_n)
        (f.hold && !i_br_taken) |=> (pc_q == $past(pc_q)));

endmodule

`default_nettype wire

/* source/lc4_pipe_if.sv */
`timescale 1ns/1ns
`default_nettype none

// fetch to decode latch contents and the decode hold back to fetch
interface fetch_if;
    import lc4_pkg::*;

    word_t  pc;
    word_t  insn;
    stall_t stall;
    logic   hold;

    modport producer (output pc, output insn, output stall, input hold);
    modport consumer (input pc, input insn, input stall, output hold);
endinterface

// decode to execute latch contents and the regfile write port back to decode
interface exec_if;
    import lc4_pkg::*;

    word_t    pc;
    word_t    insn;
    dec_ctl_t ctl;
    word_t    rs_data;
    word_t    rt_data;
    stall_t   stall;
    logic     wb_we;
    reg_sel_t wb_sel;
    word_t    wb_data;

    modport producer (
        output pc, insn, ctl, rs_data, rt_data, stall,
        input  wb_we, wb_sel, wb_data
    );
    modport consumer (
        input  pc, insn, ctl, rs_data, rt_data, stall,
        output wb_we, wb_sel, wb_data
    );
endinterface

`default_nettype wire

/* source/lc4_pkg.sv */
`default_nettype none

package lc4_pkg;

    // machine word width, shared by instructions, addresses and data
    localparam int WORD_W = 16;
    localparam int NUM_REGS = 8;

    typedef logic [WORD_W-1:0] word_t;
    typedef logic [$clog2(NUM_REGS)-1:0] reg_sel_t;

    // condition code bits, n in the msb
    typedef logic [2:0] nzp_t;

    // per-instruction stall code carried down the pipe
    typedef logic [1:0] stall_t;

    localparam stall_t STALL_NONE  = 2'd0;
    localparam stall_t STALL_FLUSH = 2'd2;
    localparam stall_t STALL_LOAD  = 2'd3;

    localparam word_t RESET_PC = 16'h8200;

    // opcodes of the supported subset
    localparam logic [3:0] OP_BR    = 4'b0000;
    localparam logic [3:0] OP_ADD   = 4'b0001;
    localparam logic [3:0] OP_AND   = 4'b0101;
    localparam logic [3:0] OP_LDR   = 4'b0110;
    localparam logic [3:0] OP_STR   = 4'b0111;
    localparam logic [3:0] OP_CONST = 4'b1001;

    // decoded control, travels with the instruction from decode to writeback
    typedef struct packed {
        reg_sel_t rs;
        reg_sel_t rt;
        reg_sel_t rd;
        logic     rs_re;
        logic     rt_re;
        logic     reg_we;
        logic     nzp_we;
        logic     is_load;
        logic     is_store;
        logic     is_branch;
    } dec_ctl_t;

endpackage

`default_nettype wire

/* source/lc4_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module lc4_regfile (
    input  wire                    gwe,
    input  wire                    i_rst_n,
    input  wire  lc4_pkg::reg_sel_t i_rs,
    input  wire  lc4_pkg::reg_sel_t i_rt,
    input  wire                    i_we,
    input  wire  lc4_pkg::reg_sel_t i_wsel,
    input  wire  lc4_pkg::word_t   i_wdata,
    output lc4_pkg::word_t         o_rs_data,
    output lc4_pkg::word_t         o_rt_data
);
    import lc4_pkg::*;

    word_t regs [NUM_REGS];

    always_ff @(posedge gwe) begin
        if (!i_rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_we) begin
            regs[i_wsel] <= i_wdata;
        end
    end

    // writeback and decode share a cycle, so pass the new value through
    assign o_rs_data = (i_we && (i_wsel == i_rs)) ? i_wdata : regs[i_rs];
    assign o_rt_data = (i_we && (i_wsel == i_rt)) ? i_wdata : regs[i_rt];

endmodule

`default_nettype wire

/* tests/tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
    output logic gwe,
    output logic o_rst_n
);
    initial begin
        gwe = 1'b0;
        forever #5 gwe = ~gwe;
    end

    // power-on reset for two rising edges
    initial begin
        o_rst_n = 1'b0;
        repeat (2) @(posedge gwe);
        o_rst_n <= 1'b1;
    end
endmodule

`default_nettype wire

/* tests/tb_lc4_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_lc4_core;
    import lc4_pkg::*;

    logic gwe, clk_rst_n, soft_rst_n;
    wire  rst_n = clk_rst_n & soft_rst_n;
    word_t cur_insn, cur_pc, dmem_rdata, dmem_addr, dmem_towrite;
    word_t wb_pc, wb_insn, rf_data;
    logic dmem_we, rf_we, nzp_we;
    stall_t wb_stall;
    reg_sel_t rf_wsel;
    nzp_t nzp_new;

    // instruction memory, data memory and the golden model's own data memory
    word_t prog [65536];
    word_t dm [65536];
    word_t gdm [65536];
    word_t g_regs [8];
    word_t g_pc, e_pc, e_insn, e_data, e_addr, e_sdata, e_next_pc, st_addr, st_data;
    nzp_t g_nzp, e_nzp;
    reg_sel_t e_sel, prev_rd;
    logic e_we, e_st, e_taken, e_is_load, prev_load, prev_taken, st_seen;
    int e_flush, e_hold, n_flush, n_load, cyc, errors, prog_len, tests, failed;

    tb_clock u_clock (.gwe(gwe), .o_rst_n(clk_rst_n));

    lc4_core i_lc4_core (
        .gwe(gwe), .i_rst_n(rst_n), .i_cur_insn(cur_insn), .i_cur_dmem_data(dmem_rdata),
        .o_cur_pc(cur_pc), .o_dmem_addr(dmem_addr), .o_dmem_we(dmem_we),
        .o_dmem_towrite(dmem_towrite), .o_wb_pc(wb_pc), .o_wb_insn(wb_insn),
        .o_wb_stall(wb_stall), .o_regfile_we(rf_we), .o_regfile_wsel(rf_wsel),
        .o_regfile_data(rf_data), .o_nzp_we(nzp_we), .o_nzp_new(nzp_new)
    );

    assign cur_insn   = prog[cur_pc];
    assign dmem_rdata = dm[dmem_addr];

    always @(posedge gwe) begin
        if (dmem_we) begin
            dm[dmem_addr] <= dmem_towrite;
        end
        st_seen <= dmem_we;
        st_addr <= dmem_addr;
        st_data <= dmem_towrite;
    end

    function automatic word_t sign_ext(input word_t v, input int bits);
        logic signed [15:0] t;
        t = v << (16 - bits);
        return t >>> (16 - bits);
    endfunction

    function automatic nzp_t cond_code(input word_t v);
        if (v == 16'h0000) begin
            return 3'b010;
        end
        return v[15] ? 3'b100 : 3'b001;
    endfunction

    // predicts the retire of the instruction at g_pc without changing state
    task automatic predict_next();
        word_t i, a, b;
        logic use_rs, use_rt, is_br;
        i = prog[g_pc];
        a = g_regs[i[8:6]];
        b = i[5] ? sign_ext(word_t'(i[4:0]), 5) : g_regs[i[2:0]];
        {use_rs, use_rt, is_br, e_we, e_st, e_taken} = '0;
        {e_data, e_addr, e_sdata} = '0;
        e_pc = g_pc;
        e_insn = i;
        e_sel = i[11:9];
        e_next_pc = g_pc + 16'd1;
        e_is_load = (i[15:12] == OP_LDR);
        case (i[15:12])
            OP_ADD, OP_AND: begin
                if (i[5] || i[5:3] == 3'b000) begin
                    e_we = 1'b1;
                    e_data = (i[15:12] == OP_ADD) ? a + b : a & b;
                    use_rs = 1'b1;
                    use_rt = ~i[5];
                end
            end
            OP_CONST: begin
                e_we = 1'b1;
                e_data = sign_ext(word_t'(i[8:0]), 9);
            end
            OP_LDR: begin
                e_we = 1'b1;
                e_data = gdm[a + sign_ext(word_t'(i[5:0]), 6)];
                use_rs = 1'b1;
            end
            OP_STR: begin
                e_st = 1'b1;
                e_addr = a + sign_ext(word_t'(i[5:0]), 6);
                e_sdata = g_regs[i[11:9]];
                use_rs = 1'b1;
            end
            OP_BR: begin
                is_br = |i[11:9];
                if (|(g_nzp & i[11:9])) begin
                    e_taken = 1'b1;
                    e_next_pc = g_pc + 16'd1 + sign_ext(word_t'(i[8:0]), 9);
                end
            end
            default: ;
        endcase
        e_nzp = cond_code(e_data);
        e_flush = prev_taken ? 2 : 0;
        e_hold = (prev_load && ((use_rs && i[8:6] == prev_rd) ||
                  (use_rt && i[2:0] == prev_rd) || is_br)) ? 1 : 0;
    endtask

    always @(posedge gwe) begin
        if (rst_n && cyc >= 4 && wb_stall == STALL_NONE) begin
            if (e_we) g_regs[e_sel] = e_data;
            if (e_we) g_nzp = e_nzp;
            if (e_st) gdm[e_addr] = e_sdata;
            prev_load = e_is_load;
            prev_rd = e_sel;
            prev_taken = e_taken;
            g_pc = e_next_pc;
            predict_next();
        end
    end

    // cycles since reset release, and bubbles seen since the last real retire
    always @(posedge gwe) begin
        if (!rst_n) cyc <= 0;
        else if (cyc < 100) cyc <= cyc + 1;
        if (!rst_n || cyc < 4 || wb_stall == STALL_NONE) begin
            n_flush <= 0;
            n_load <= 0;
        end else if (wb_stall == STALL_FLUSH) n_flush <= n_flush + 1;
        else if (wb_stall == STALL_LOAD) n_load <= n_load + 1;
    end

    wire retire = (cyc >= 4) && (wb_stall == STALL_NONE);

    task automatic flag_mismatch(input string name, input word_t got, input word_t exp);
        $display("MISMATCH %s: got %h expected %h", name, got, exp);
        errors++;
    endtask

    task automatic flag_failure(input string msg);
        $display("check failed: %s", msg);
        errors++;
    endtask

    a_reset_idle : assert property (@(posedge gwe) disable iff (!rst_n)
        (cyc < 4) |-> (wb_stall == STALL_FLUSH && !rf_we && !dmem_we))
        else flag_failure("pipeline not empty before the first retire");
    a_first_pc : assert property (@(posedge gwe) disable iff (!rst_n)
        (cyc == 4) |-> (wb_stall == STALL_NONE && wb_pc == RESET_PC))
        else flag_failure("first retire at 16'h8200 missing four cycles after reset");
    a_pc : assert property (@(posedge gwe) disable iff (!rst_n) retire |-> wb_pc == e_pc)
        else flag_mismatch("o_wb_pc", $sampled(wb_pc), $sampled(e_pc));
    a_insn : assert property (@(posedge gwe) disable iff (!rst_n) retire |-> wb_insn == e_insn)
        else flag_mismatch("o_wb_insn", $sampled(wb_insn), $sampled(e_insn));
    a_we : assert property (@(posedge gwe) disable iff (!rst_n)
        retire |-> rf_we == e_we)
        else flag_mismatch("o_regfile_we", 16'($sampled(rf_we)), 16'($sampled(e_we)));
    a_nzp_we : assert property (@(posedge gwe) disable iff (!rst_n)
        retire |-> nzp_we == e_we)
        else flag_mismatch("o_nzp_we", 16'($sampled(nzp_we)), 16'($sampled(e_we)));
    a_wsel : assert property (@(posedge gwe) disable iff (!rst_n)
        (retire && e_we) |-> rf_wsel == e_sel)
        else flag_mismatch("o_regfile_wsel", 16'($sampled(rf_wsel)), 16'($sampled(e_sel)));
    a_data : assert property (@(posedge gwe) disable iff (!rst_n)
        (retire && e_we) |-> rf_data == e_data)
        else flag_mismatch("o_regfile_data", $sampled(rf_data), $sampled(e_data));
    a_nzp : assert property (@(posedge gwe) disable iff (!rst_n)
        (retire && e_we) |-> nzp_new == e_nzp)
        else flag_mismatch("o_nzp_new", 16'($sampled(nzp_new)), 16'($sampled(e_nzp)));
    a_store : assert property (@(posedge gwe) disable iff (!rst_n) retire |-> st_seen == e_st)
        else flag_failure("data memory write does not match the retiring instruction");
    a_st_addr : assert property (@(posedge gwe) disable iff (!rst_n)
        (retire && e_st) |-> st_addr == e_addr)
        else flag_mismatch("o_dmem_addr", $sampled(st_addr), $sampled(e_addr));
    a_st_data : assert property (@(posedge gwe) disable iff (!rst_n)
        (retire && e_st) |-> st_data == e_sdata)
        else flag_mismatch("o_dmem_towrite", $sampled(st_data), $sampled(e_sdata));
    a_flush_gap : assert property (@(posedge gwe) disable iff (!rst_n)
        retire |-> n_flush == e_flush)
        else flag_mismatch("flush bubbles", 16'($sampled(n_flush)), 16'($sampled(e_flush)));
    a_load_gap : assert property (@(posedge gwe) disable iff (!rst_n)
        retire |-> n_load == e_hold)
        else flag_mismatch("load bubbles", 16'($sampled(n_load)), 16'($sampled(e_hold)));

    function automatic word_t enc_alu(input logic [3:0] op, input int rd, rs, rt);
        return {op, 3'(rd), 3'(rs), 3'b000, 3'(rt)};
    endfunction

    function automatic word_t enc_alui(input logic [3:0] op, input int rd, rs, imm);
        return {op, 3'(rd), 3'(rs), 1'b1, 5'(imm)};
    endfunction

    function automatic word_t enc_mem(input logic [3:0] op, input int rd, rs, imm);
        return {op, 3'(rd), 3'(rs), 6'(imm)};
    endfunction

    function automatic word_t enc_imm9(input logic [3:0] op, input int f, imm);
        return {op, 3'(f), 9'(imm)};
    endfunction

    task automatic emit(input word_t insn);
        prog[RESET_PC + word_t'(prog_len)] = insn;
        prog_len++;
    endtask

    // holds the DUT in reset and clears the program so the caller can build one
    task automatic start_test();
        @(posedge gwe);
        soft_rst_n <= 1'b0;
        @(posedge gwe);
        for (int a = 0; a < 65536; a++) begin
            prog[a] = 16'h0000;
        end
        prog_len = 0;
    endtask

    task automatic run_test(input string name);
        int start_errors, cycles;
        start_errors = errors;
        for (int a = 0; a < 65536; a++) begin
            dm[a] = word_t'(a * 40503) ^ 16'h5a3c;
            gdm[a] = dm[a];
        end
        for (int r = 0; r < 8; r++) begin
            g_regs[r] = 16'h0000;
        end
        g_nzp = 3'b000;
        g_pc = RESET_PC;
        {prev_load, prev_taken, prev_rd} = '0;
        predict_next();
        @(posedge gwe);
        soft_rst_n <= 1'b1;
        cycles = 0;
        while (g_pc < RESET_PC + word_t'(prog_len) && cycles < 30 + 6 * prog_len) begin
            @(negedge gwe);
            cycles++;
        end
        if (g_pc < RESET_PC + word_t'(prog_len)) begin
            flag_failure("timeout before the end of the program");
        end
        repeat (2) @(posedge gwe);
        tests++;
        if (errors != start_errors) failed++;
        $display("test %s: %0d failed checks", name, errors - start_errors);
    endtask

    initial begin
        int kind;
        soft_rst_n = 1'b1;
        {errors, tests, failed, prog_len} = '0;
        for (int a = 0; a < 65536; a++) begin
            prog[a] = 16'h0000;
            dm[a] = 16'h0000;
        end
        void'($urandom(83520));
        for (int w = 0; w < 8 && clk_rst_n !== 1'b1; w++) begin
            @(posedge gwe);
        end
        if (clk_rst_n !== 1'b1) begin
            flag_failure("power-on reset was never released");
        end

        start_test();
        emit(enc_imm9(OP_CONST, 1, 3));
        emit(enc_imm9(OP_CONST, 2, -4));
        run_test("reset");

        start_test();
        emit(enc_imm9(OP_CONST, 1, 5));
        emit(enc_alu(OP_ADD, 2, 1, 1));
        emit(enc_alui(OP_AND, 3, 2, -1));
        emit(enc_alui(OP_ADD, 3, 3, -13));
        emit(enc_imm9(OP_CONST, 4, -2));
        emit(enc_alu(OP_AND, 5, 4, 3));
        emit(enc_alu(OP_ADD, 6, 5, 2));
        emit(enc_alui(OP_ADD, 6, 6, 0));
        run_test("bypass");

        start_test();
        emit(enc_imm9(OP_CONST, 1, 10));
        emit(enc_mem(OP_LDR, 2, 1, 3));
        emit(enc_alu(OP_ADD, 3, 2, 1));
        emit(enc_mem(OP_LDR, 4, 3, 0));
        emit(enc_alui(OP_ADD, 4, 4, 1));
        emit(enc_mem(OP_LDR, 5, 1, -2));
        emit(enc_alu(OP_AND, 6, 1, 5));
        run_test("load_use");

        start_test();
        emit(enc_imm9(OP_CONST, 1, 20));
        emit(enc_imm9(OP_CONST, 2, -7));
        emit(enc_alu(OP_ADD, 3, 2, 2));
        emit(enc_mem(OP_STR, 3, 1, 2));
        emit(enc_mem(OP_LDR, 4, 1, 2));
        emit(enc_mem(OP_STR, 4, 1, 5));
        emit(enc_mem(OP_LDR, 5, 1, 5));
        emit(enc_alu(OP_ADD, 6, 5, 4));
        run_test("store_forward");

        start_test();
        emit(enc_imm9(OP_CONST, 1, 1));
        emit(enc_imm9(OP_BR, 3'b001, 2));
        emit(enc_imm9(OP_CONST, 2, 9));
        emit(enc_imm9(OP_CONST, 2, 8));
        emit(enc_alui(OP_ADD, 1, 1, -1));
        emit(enc_imm9(OP_BR, 3'b100, 1));
        emit(enc_imm9(OP_BR, 3'b010, 1));
        emit(enc_imm9(OP_CONST, 3, 3));
        emit(enc_mem(OP_LDR, 5, 0, 0));
        emit(enc_imm9(OP_BR, 3'b111, 0));
        emit(enc_imm9(OP_CONST, 4, 4));
        run_test("branch");

        start_test();
        for (int k = 0; k < 200; k++) begin
            kind = $urandom_range(0, 9);
            case (kind)
                0: emit(enc_alu(OP_ADD, $urandom, $urandom, $urandom));
                1: emit(enc_alui(OP_ADD, $urandom, $urandom, $urandom));
                2: emit(enc_alu(OP_AND, $urandom, $urandom, $urandom));
                3: emit(enc_alui(OP_AND, $urandom, $urandom, $urandom));
                4: emit(enc_imm9(OP_CONST, $urandom, $urandom));
                5, 6: emit(enc_mem(OP_LDR, $urandom, $urandom, $urandom));
                7: emit(enc_mem(OP_STR, $urandom, $urandom, $urandom));
                // offsets stay forward so the program always reaches its end
                8: emit(enc_imm9(OP_BR, $urandom, $urandom_range(0, 6)));
                default: emit({4'b0010, 12'($urandom)});
            endcase
        end
        run_test("random");

        $display("tests %0d, tests failed %0d, checks failed %0d", tests, failed, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end
endmodule

`default_nettype wire
